//--- tb.f
verilog/rs_pkg.sv
verilog/issue_if.sv
verilog/alu_unit.sv
verilog/latency_timer.sv
verilog/rs_entry.sv
verilog/rs_array.sv
verilog/exec_ctrl.sv
verilog/rs_top.sv
tests/tb_rs_top.sv

//--- tests/tb_rs_top.sv
/*
 * Testbench for the issue slice
 * LFSR driven dispatches with internal and external dependencies,
 * a reference model and per-tag scoreboard checked on every result
 */
`timescale 1ns/100ps
`default_nettype none

module tb_rs_top;
	import rs_pkg::*;

	localparam int RS_ENTRIES = 4;
	localparam int MUL_CYCLES = 3;
	localparam int N_RANDOM   = 40;
	localparam int N_FLUSHED  = RS_ENTRIES + 1;     // One executing, the rest fill the station
	localparam int N_INSTR    = N_RANDOM + RS_ENTRIES + 2 + 5 + 2 * N_FLUSHED;
	localparam int TIMEOUT_CYCLES = N_INSTR * (MUL_CYCLES + 6) + 100;
	localparam int N_INTERNAL = 24;                // Tags 24 and up come from cdb2_in

	logic             clock;
	logic             reset;
	logic             flush;
	logic             dispatch_valid;
	rs_payload_t      dispatch_payload;
	logic             dispatch_ready;
	cdb_t             cdb2_in;
	logic             result_valid;
	logic [TAG_W-1:0] result_tag;
	logic [XLEN-1:0]  result_data;

	logic [31:0]      lfsr;
	logic [XLEN-1:0]  exp_data [PRF_SIZE];     // Expected value per dest tag
	logic             pending [PRF_SIZE];      // Result still owed
	logic [XLEN-1:0]  ext_val [PRF_SIZE];      // Data for external tags
	logic             ext_wait [PRF_SIZE];     // External broadcast queued
	logic             ext_done [PRF_SIZE];
	int               ext_delay [PRF_SIZE];
	int               ext_uses;
	int               next_dest;
	int               last_dest;
	logic             have_last;
	logic             saw_full;
	int               dispatched;
	int               flushed;
	int               results_seen;
	int               cycle_count;

	rs_top #(.RS_ENTRIES(RS_ENTRIES), .MUL_CYCLES(MUL_CYCLES)) rs_top_i (
		.clock            (clock),
		.reset            (reset),
		.flush            (flush),
		.dispatch_valid   (dispatch_valid),
		.dispatch_payload (dispatch_payload),
		.dispatch_ready   (dispatch_ready),
		.cdb2_in          (cdb2_in),
		.result_valid     (result_valid),
		.result_tag       (result_tag),
		.result_data      (result_data)
	);

	always #10 clock = ~clock;                     // 20 ns period

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);  // One step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Expected result straight from the opcode definitions
	function automatic logic [XLEN-1:0] ref_result(input alu_func_t f,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [63:0] wide;
		wide = 64'(a) * 64'(b);
		case (f)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_XOR: return a ^ b;
			default: return wide[XLEN-1:0];        // Multiply keeps the low word
		endcase
	endfunction

	function automatic int work_left();
		int n;
		n = 0;
		for (int t = 0; t < PRF_SIZE; t++)
			n += int'(pending[t]) + int'(ext_wait[t]);
		return n;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
		input logic [TAG_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp)
			fail_run($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
	endtask

	// External broadcasts never share a cycle with a CDB 1 result
	task automatic send_ext();
		for (int e = N_INTERNAL; e < PRF_SIZE; e++)
			if (ext_wait[e] && ext_delay[e] == 0 && !result_valid && !cdb2_in.valid)
			begin
				cdb2_in = '{valid: 1'b1, tag: TAG_W'(e), data: ext_val[e]};
				ext_wait[e] = 1'b0;
				ext_done[e] = 1'b1;
			end
	endtask

	task automatic step();
		@(negedge clock);
		dispatch_valid = 1'b0;
		cdb2_in        = '0;
		for (int e = N_INTERNAL; e < PRF_SIZE; e++)
			if (ext_wait[e] && ext_delay[e] != 0)
				ext_delay[e]--;
		send_ext();
	endtask

	task automatic resolve_operand(input int src, input logic [XLEN-1:0] val,
		output logic [XLEN-1:0] op, output logic op_valid, output logic [XLEN-1:0] known);
		known    = (src < 0) ? val : (src < N_INTERNAL) ? exp_data[src] : ext_val[src];
		op_valid = (src < 0) || (src < N_INTERNAL ? !pending[src] : ext_done[src]);
		op       = op_valid ? known : XLEN'(src);  // Tag in the low bits
		if (src >= N_INTERNAL && !ext_done[src] && !ext_wait[src])
		begin
			ext_wait[src]  = 1'b1;
			ext_delay[src] = ext_uses % 3;         // Zero lands in the dispatch cycle
			ext_uses++;
		end
	endtask

	// Source -1 means a plain value
	task automatic dispatch_op(input alu_func_t f, input int src_a, input int src_b,
		input logic [XLEN-1:0] val_a, input logic [XLEN-1:0] val_b,
		output logic [TAG_W-1:0] dest);
		rs_payload_t     p;
		logic [XLEN-1:0] oa;
		logic [XLEN-1:0] ob;
		logic            va;
		logic            vb;
		logic [XLEN-1:0] ka;
		logic [XLEN-1:0] kb;
		while (!dispatch_ready)
		begin
			saw_full = 1'b1;
			step();
		end
		resolve_operand(src_a, val_a, oa, va, ka);
		resolve_operand(src_b, val_b, ob, vb, kb);
		while (pending[next_dest])
			next_dest = (next_dest + 1) % N_INTERNAL;
		dest      = TAG_W'(next_dest);
		next_dest = (next_dest + 1) % N_INTERNAL;
		p = '{func: f, opa: oa, opa_valid: va, opb: ob, opb_valid: vb, dest: dest};
		exp_data[dest]   = ref_result(f, ka, kb);
		pending[dest]    = 1'b1;
		dispatch_payload = p;
		dispatch_valid   = 1'b1;
		send_ext();
		last_dest  = dest;
		have_last  = 1'b1;
		dispatched++;
		step();
	endtask

	function automatic int pick_source();
		logic [1:0] k;
		k = 2'(take_bits(2));
		if (k == 2'd0 && have_last)
			return last_dest;                      // Often still in flight
		if (k == 2'd1)
			return N_INTERNAL + int'(take_bits(3));
		return -1;
	endfunction

	task automatic send_random();
		alu_func_t        f;
		logic [XLEN-1:0]  va;
		logic [XLEN-1:0]  vb;
		int               sa;
		int               sb;
		logic [TAG_W-1:0] d;
		f  = alu_func_t'(3'(take_bits(3) % 5));
		va = take_bits(32);
		vb = take_bits(32);
		sa = pick_source();
		sb = pick_source();
		dispatch_op(f, sa, sb, va, vb, d);
		repeat (take_bits(2)) step();              // Idle gap of 0 to 3 cycles
	endtask

	task automatic wait_drain();
		while (work_left() != 0)
			step();
	endtask

	task automatic isolated_latency(input alu_func_t f);
		logic [XLEN-1:0]  va;
		logic [XLEN-1:0]  vb;
		logic [TAG_W-1:0] d;
		int               cycles;
		wait_drain();
		step();
		va = take_bits(32);
		vb = take_bits(32);
		dispatch_op(f, -1, -1, va, vb, d);         // Returns one edge after dispatch
		cycles = 1;                                // Counts up to the edge that samples the result
		while (!result_valid)
		begin
			step();
			cycles++;
		end
		check_latency("result latency", cycles, (f == ALU_MUL) ? MUL_CYCLES + 2 : 3);
		check_tag("result_tag", result_tag, d);
	endtask

	task automatic flush_test();
		logic [XLEN-1:0]  va;
		logic [XLEN-1:0]  vb;
		logic [TAG_W-1:0] d;
		wait_drain();
		for (int i = 0; i < N_FLUSHED; i++)
		begin
			va = take_bits(32);
			vb = take_bits(32);
			dispatch_op(ALU_MUL, -1, -1, va, vb, d);
		end
		while (result_valid)
			step();                                // A finished result still counts
		check_flag("dispatch_ready", dispatch_ready, 1'b0);  // Station full before the flush
		flush   = 1'b1;
		flushed += work_left();
		for (int t = 0; t < PRF_SIZE; t++)
		begin
			pending[t]  = 1'b0;                    // Flushed tags owe nothing
			ext_wait[t] = 1'b0;
		end
		have_last = 1'b0;
		step();
		flush = 1'b0;
		repeat (MUL_CYCLES + 4) step();            // Any result here is a leak
		check_flag("dispatch_ready", dispatch_ready, 1'b1);
		repeat (N_FLUSHED) send_random();
		wait_drain();
	endtask

	////////////////////////////////////////////////////////////
	// Scoreboard and timeout
	////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin
		if (!reset && result_valid)
		begin
			if (!pending[result_tag])
				fail_run($sformatf("Result on tag %0d at %0t with nothing owed for that tag",
					result_tag, $time));
			check_data("result_data", result_data, exp_data[result_tag]);
			pending[result_tag] = 1'b0;
			results_seen++;
		end
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
			fail_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

	initial
	begin
		logic [XLEN-1:0]  va;
		logic [XLEN-1:0]  vb;
		logic [TAG_W-1:0] d;
		clock = 1'b0;
		reset = 1'b1;
		flush = 1'b0;
		dispatch_valid   = 1'b0;
		dispatch_payload = '0;
		cdb2_in          = '0;
		lfsr = 32'h52b5;
		ext_uses     = 0;
		next_dest    = 0;
		last_dest    = 0;
		have_last    = 1'b0;
		saw_full     = 1'b0;
		dispatched   = 0;
		flushed      = 0;
		results_seen = 0;
		cycle_count  = 0;
		for (int t = 0; t < PRF_SIZE; t++)
		begin
			exp_data[t]  = '0;
			pending[t]   = 1'b0;
			ext_wait[t]  = 1'b0;
			ext_done[t]  = 1'b0;
			ext_delay[t] = 0;
			ext_val[t]   = take_bits(32);
		end
		repeat (3) @(negedge clock);
		reset = 1'b0;
		check_flag("dispatch_ready", dispatch_ready, 1'b1);
		check_flag("result_valid", result_valid, 1'b0);
		repeat (N_RANDOM) send_random();           // Mixed opcodes and wake-ups
		wait_drain();
		saw_full = 1'b0;
		for (int i = 0; i < RS_ENTRIES + 2; i++)
		begin
			va = take_bits(32);
			vb = take_bits(32);
			dispatch_op(ALU_MUL, -1, -1, va, vb, d);
		end
		wait_drain();
		if (!saw_full)
			fail_run("dispatch_ready never dropped with the station full");
		for (int f = 0; f < 5; f++)
			isolated_latency(alu_func_t'(3'(f)));
		flush_test();
		if (work_left() == 0 && results_seen == dispatched - flushed)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
			fail_run("Result count does not match the instructions that should complete");
	end

endmodule

`default_nettype wire

//--- verilog/alu_unit.sv
/*
 * ALU datapath
 * Combinational add, subtract, and, xor and low-half multiply
 */
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
	input  rs_pkg::alu_func_t       func,
	input  logic [rs_pkg::XLEN-1:0] opa,
	input  logic [rs_pkg::XLEN-1:0] opb,
	output logic [rs_pkg::XLEN-1:0] result
);
	import rs_pkg::*;

	logic [2*XLEN-1:0] product;                   // Full width product

	assign product = opa * opb;

	always_comb
	begin
		case (func)
			ALU_ADD: result = opa + opb;
			ALU_SUB: result = opa - opb;
			ALU_AND: result = opa & opb;
			ALU_XOR: result = opa ^ opb;
			ALU_MUL: result = product[XLEN-1:0];  // Upper half dropped
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/exec_ctrl.sv
/*
 * Execution controller
 * Takes one issued instruction at a time, waits out its latency and
 * broadcasts the registered result on CDB 1 for a single cycle
 */
`timescale 1ns/100ps
`default_nettype none

module exec_ctrl #(
	parameter int MUL_CYCLES = 3                  // Multiply latency of one or more cycles
) (
	input  logic         clock,
	input  logic         reset,
	input  logic         flush,                   // Abandon the op in flight
	issue_if.exec        issue,
	output rs_pkg::cdb_t cdb1                     // Result broadcast
);
	import rs_pkg::*;

	typedef enum logic [1:0] {IDLE, EXEC, BCAST} state_t;

	state_t           state;
	state_t           state_next;
	logic             start;                      // Issue transfer this cycle
	logic             expired;                    // Latency done
	alu_func_t        func_q;
	logic [XLEN-1:0]  opa_q;
	logic [XLEN-1:0]  opb_q;
	logic [TAG_W-1:0] dest_q;
	logic [XLEN-1:0]  alu_result;
	logic [XLEN-1:0]  result_q;

	assign issue.ready = (state == IDLE);
	assign start       = issue.valid && issue.ready && !flush;

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:    if (start) state_next = EXEC;
			EXEC:    if (expired) state_next = BCAST;
			BCAST:   state_next = IDLE;           // One broadcast cycle
			default: state_next = IDLE;
		endcase
		if (flush)
			state_next = IDLE;                    // No broadcast after flush
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clock)
	begin
		if (start)
		begin
			func_q <= issue.func;                 // Operands latched on accept
			opa_q  <= issue.opa;
			opb_q  <= issue.opb;
			dest_q <= issue.dest;
		end
		if (state == EXEC && expired)
			result_q <= alu_result;
	end

	latency_timer #(.MUL_CYCLES(MUL_CYCLES)) timer_i (
		.clock   (clock),
		.reset   (reset),
		.start   (start),
		.long_op (issue.func == ALU_MUL),
		.expired (expired)
	);

	alu_unit alu_i (
		.func   (func_q),
		.opa    (opa_q),
		.opb    (opb_q),
		.result (alu_result)
	);

	assign cdb1.valid = (state == BCAST);
	assign cdb1.tag   = dest_q;
	assign cdb1.data  = result_q;

	// Broadcast lands a fixed number of cycles after the accept
	a_short_latency: assert property (@(posedge clock) disable iff (reset || flush)
		start && (issue.func != ALU_MUL) |-> ##2 cdb1.valid);
	a_mul_latency: assert property (@(posedge clock) disable iff (reset || flush)
		start && (issue.func == ALU_MUL) |-> ##(MUL_CYCLES + 1) cdb1.valid);

endmodule

`default_nettype wire

//--- verilog/issue_if.sv
/*
 * Issue channel
 * Carries one ready instruction from the station to the execution
 * controller; a transfer happens on an edge with valid and ready high
 */
`timescale 1ns/100ps
`default_nettype none

interface issue_if;
	import rs_pkg::*;

	logic             valid;                      // Station has a ready entry
	logic             ready;                      // Execution unit is idle
	alu_func_t        func;
	logic [XLEN-1:0]  opa;
	logic [XLEN-1:0]  opb;
	logic [TAG_W-1:0] dest;

	modport station (output valid, func, opa, opb, dest, input ready);
	modport exec (input valid, func, opa, opb, dest, output ready);

endinterface

`default_nettype wire

//--- verilog/latency_timer.sv
/*
 * Execution latency timer
 * Down-counter loaded on issue; expired marks the last execute cycle
 */
`timescale 1ns/100ps
`default_nettype none

module latency_timer #(
	parameter int MUL_CYCLES = 3
) (
	input  logic clock,
	input  logic reset,
	input  logic start,                           // Load a new count
	input  logic long_op,                         // Multiply latency
	output logic expired                          // Count at zero
);
	localparam int CNT_W = (MUL_CYCLES > 1) ? $clog2(MUL_CYCLES) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clock)
	begin
		if (reset)
			count <= '0;
		else if (start)
			count <= long_op ? CNT_W'(MUL_CYCLES - 1) : '0;
		else if (count != '0)
			count <= count - 1'b1;                // Hold at zero
	end

	assign expired = (count == '0);

	a_no_underflow: assert property (@(posedge clock) disable iff (reset)
		!start && (count == '0) |=> (count == '0));

endmodule

`default_nettype wire

//--- verilog/rs_array.sv
/*
 * Reservation station array
 * Puts each accepted dispatch into the lowest free entry, picks the
 * lowest ready entry for issue and frees it when the execution
 * controller takes it
 */
`timescale 1ns/100ps
`default_nettype none

module rs_array #(
	parameter int RS_ENTRIES = 4                  // Number of entries
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                flush,
	input  logic                dispatch_valid,
	input  rs_pkg::rs_payload_t dispatch_payload,
	output logic                dispatch_ready,   // Some entry is free
	input  rs_pkg::cdb_t        cdb1,
	input  rs_pkg::cdb_t        cdb2,
	issue_if.station            issue
);
	import rs_pkg::*;

	localparam int IDX_W = (RS_ENTRIES > 1) ? $clog2(RS_ENTRIES) : 1;

	logic [RS_ENTRIES-1:0] in_use;
	logic [RS_ENTRIES-1:0] ready;
	logic [RS_ENTRIES-1:0] load;                  // One-hot dispatch steering
	logic [RS_ENTRIES-1:0] grant;                 // One-hot issue release
	rs_payload_t           entry_data [RS_ENTRIES];
	logic [IDX_W-1:0]      free_idx;              // Lowest free entry
	logic [IDX_W-1:0]      sel_idx;               // Lowest ready entry

	////////////////////////////////////////////////////////////
	// Priority pickers
	////////////////////////////////////////////////////////////

	always_comb
	begin
		free_idx = '0;
		sel_idx  = '0;
		for (int i = RS_ENTRIES - 1; i >= 0; i--)
		begin
			if (!in_use[i])
				free_idx = IDX_W'(i);             // Last hit is the lowest index
			if (ready[i])
				sel_idx = IDX_W'(i);
		end
	end

	assign dispatch_ready = ~&in_use;             // From registered in_use only

	assign issue.valid = |ready;                  // Re-selected every cycle
	assign issue.func  = entry_data[sel_idx].func;
	assign issue.opa   = entry_data[sel_idx].opa;
	assign issue.opb   = entry_data[sel_idx].opb;
	assign issue.dest  = entry_data[sel_idx].dest;

	////////////////////////////////////////////////////////////
	// Entries
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < RS_ENTRIES; g++)
	begin : g_entry
		assign load[g]  = dispatch_valid && dispatch_ready && (free_idx == IDX_W'(g));
		assign grant[g] = issue.valid && issue.ready && (sel_idx == IDX_W'(g));

		rs_entry entry_i (
			.clock       (clock),
			.reset       (reset),
			.flush       (flush),
			.load        (load[g]),
			.load_data   (dispatch_payload),
			.cdb1        (cdb1),
			.cdb2        (cdb2),
			.issue_grant (grant[g]),
			.in_use      (in_use[g]),
			.ready       (ready[g]),
			.entry_data  (entry_data[g])
		);
	end

	a_load_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(load));
	a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(grant));

endmodule

`default_nettype wire

//--- verilog/rs_entry.sv
/*
 * Reservation station entry
 * Holds one dispatched instruction and watches both result buses
 * for operands still waiting on a tag, also in the cycle the entry
 * is loaded. Ready once both operands hold values. An issue grant
 * frees the slot, a flush frees it regardless of anything else.
 */
`timescale 1ns/100ps
`default_nettype none

module rs_entry (
	input  logic                clock,
	input  logic                reset,
	input  logic                flush,        // Drop the entry
	input  logic                load,         // Write load_data into the slot
	input  rs_pkg::rs_payload_t load_data,    // Incoming dispatch record
	input  rs_pkg::cdb_t        cdb1,         // Broadcast from own unit
	input  rs_pkg::cdb_t        cdb2,         // Broadcast from other unit
	input  logic                issue_grant,  // Entry sent to execution
	output logic                in_use,       // Slot occupied
	output logic                ready,        // Both operands are values
	output rs_pkg::rs_payload_t entry_data    // Stored record
);
	import rs_pkg::*;

	rs_payload_t base;                            // Record before wake-up
	rs_payload_t next_data;                       // Record after wake-up
	logic        snoop;                           // Entry live or being loaded
	logic        a_hit1;
	logic        a_hit2;
	logic        b_hit1;
	logic        b_hit2;

	////////////////////////////////////////////////////////////
	// Operand wake-up
	////////////////////////////////////////////////////////////

	assign base  = load ? load_data : entry_data;  // New record snoops too
	assign snoop = load | in_use;

	assign a_hit1 = snoop && !base.opa_valid && cdb1.valid
		&& (cdb1.tag == base.opa[TAG_W-1:0]);
	assign a_hit2 = snoop && !base.opa_valid && cdb2.valid
		&& (cdb2.tag == base.opa[TAG_W-1:0]);
	assign b_hit1 = snoop && !base.opb_valid && cdb1.valid
		&& (cdb1.tag == base.opb[TAG_W-1:0]);
	assign b_hit2 = snoop && !base.opb_valid && cdb2.valid
		&& (cdb2.tag == base.opb[TAG_W-1:0]);

	always_comb
	begin
		next_data = base;
		if (a_hit1)
		begin
			next_data.opa       = cdb1.data;      // Tag replaced by value
			next_data.opa_valid = 1'b1;
		end
		if (a_hit2)
		begin
			next_data.opa       = cdb2.data;
			next_data.opa_valid = 1'b1;
		end
		if (b_hit1)
		begin
			next_data.opb       = cdb1.data;
			next_data.opb_valid = 1'b1;
		end
		if (b_hit2)
		begin
			next_data.opb       = cdb2.data;
			next_data.opb_valid = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		entry_data <= next_data;                  // Payload, meaningful only in use
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			in_use <= 1'b0;
		else if (flush)
			in_use <= 1'b0;                       // Flush beats load and grant
		else if (load)
			in_use <= 1'b1;
		else if (issue_grant)
			in_use <= 1'b0;                       // Freed on the transfer edge
	end

	assign ready = in_use && entry_data.opa_valid && entry_data.opb_valid;

	// The array must only steer a dispatch into a free slot
	a_load_free: assert property (@(posedge clock) disable iff (reset)
		load |-> !in_use);

endmodule

`default_nettype wire

//--- verilog/rs_pkg.sv
/*
 * Shared definitions for the issue slice
 * Data and tag widths, the opcode set, the result broadcast record
 * and the record that travels from dispatch into a station entry
 */
`default_nettype none

package rs_pkg;

	localparam int XLEN     = 32;                 // Data width
	localparam int PRF_SIZE = 32;                 // Physical registers
	localparam int TAG_W    = $clog2(PRF_SIZE);   // Physical register tag width

	// Opcodes handled by the single execution unit
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_XOR = 3'd3,
		ALU_MUL = 3'd4                            // Multi-cycle, low half kept
	} alu_func_t;

	// Result broadcast bus
	typedef struct packed {
		logic             valid;                  // Broadcast this cycle
		logic [TAG_W-1:0] tag;                    // Producing dest tag
		logic [XLEN-1:0]  data;                   // Result value
	} cdb_t;

	// Dispatch record, one per instruction
	typedef struct packed {
		alu_func_t        func;
		logic [XLEN-1:0]  opa;                    // Value, or tag in low bits
		logic             opa_valid;              // High when opa holds a value
		logic [XLEN-1:0]  opb;                    // Value, or tag in low bits
		logic             opb_valid;              // High when opb holds a value
		logic [TAG_W-1:0] dest;                   // Dest physical register
	} rs_payload_t;

endpackage

`default_nettype wire

//--- verilog/rs_top.sv
/*
 * Issue slice top level
 * Reservation station array feeding a single execution unit, with
 * a second result bus from outside and CDB 1 brought out as ports
 */
`timescale 1ns/100ps
`default_nettype none

module rs_top #(
	parameter int RS_ENTRIES = 4,                 // Station depth
	parameter int MUL_CYCLES = 3                  // Multiply latency
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      flush,             // Clear station and unit
	input  logic                      dispatch_valid,
	input  rs_pkg::rs_payload_t       dispatch_payload,
	output logic                      dispatch_ready,
	input  rs_pkg::cdb_t              cdb2_in,           // External broadcast
	output logic                      result_valid,      // CDB 1 out
	output logic [rs_pkg::TAG_W-1:0]  result_tag,
	output logic [rs_pkg::XLEN-1:0]   result_data
);
	import rs_pkg::*;

	cdb_t cdb1;                                   // Own unit broadcast

	issue_if issue_bus ();

	rs_array #(.RS_ENTRIES(RS_ENTRIES)) rs_array_i (
		.clock            (clock),
		.reset            (reset),
		.flush            (flush),
		.dispatch_valid   (dispatch_valid),
		.dispatch_payload (dispatch_payload),
		.dispatch_ready   (dispatch_ready),
		.cdb1             (cdb1),
		.cdb2             (cdb2_in),
		.issue            (issue_bus.station)
	);

	exec_ctrl #(.MUL_CYCLES(MUL_CYCLES)) exec_ctrl_i (
		.clock (clock),
		.reset (reset),
		.flush (flush),
		.issue (issue_bus.exec),
		.cdb1  (cdb1)
	);

	assign result_valid = cdb1.valid;
	assign result_tag   = cdb1.tag;
	assign result_data  = cdb1.data;

endmodule

`default_nettype wire
